// File: build.f
common/video_timing_pkg.sv
common/vdp_pkg.sv
hw/vdp_ram.sv
hw/raster_timing.sv
text_mode/text_fetch.sv
text_mode/color_output.sv
hw/vdp_top.sv
tests/vdp_asserts.sv
tests/vdp_tb.sv

// File: common/vdp_pkg.sv
package vdp_pkg;

  // Video RAM is 16 KB, byte wide
  typedef logic [13:0] vram_addr_t;
  typedef logic [7:0]  vram_data_t;

  // Index into the colour RAM
  typedef logic [3:0] color_index_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // Text mode geometry
  localparam int TEXT_COLUMNS = 40;
  localparam int CHAR_WIDTH   = 6;
  localparam int CHAR_HEIGHT  = 8;

  localparam int PALETTE_SIZE = 16;

  // Console colours loaded into the colour RAM at start
  localparam rgb_t DEFAULT_PALETTE [PALETTE_SIZE] = '{
    24'h000000,  // transparent, shown as black
    24'h010101,  // black
    24'h3eb849,  // medium green
    24'h74d07d,  // light green
    24'h5955e0,  // dark blue
    24'h8076f1,  // light blue
    24'h993e31,  // dark red
    24'h65dbef,  // cyan
    24'hdb6559,  // medium red
    24'hff897d,  // light red
    24'hccc35e,  // dark yellow
    24'hded087,  // light yellow
    24'h3aa241,  // dark green
    24'hb766b5,  // magenta
    24'h777777,  // gray
    24'hffffff   // white
  };

endpackage

// File: common/video_timing_pkg.sv
package video_timing_pkg;

  // Horizontal timing in clk cycles, 640x480 at 60 Hz
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // Vertical timing in lines
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 11;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 31;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // Left border is H_BORDER plus the text mode adjustment
  localparam int H_BORDER     = 64;
  localparam int H_BORDER_ADJ = 12;

  // Top and bottom border in lines
  localparam int V_BORDER = 48;

  // Length of the frame interrupt pulse in cycles
  localparam int INT_LENGTH = 64;

  // Raster position counters
  typedef logic [9:0] hcount_t;
  typedef logic [9:0] vcount_t;

endpackage

// File: hw/raster_timing.sv
`timescale 1ns/100ps

module raster_timing (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        vert_retrace_int,
  output video_timing_pkg::hcount_t   hc,
  output video_timing_pkg::vcount_t   vc,
  output logic                        hs,
  output logic                        vs,
  output logic                        de,
  output logic                        border,
  output logic                        n_int,
  output logic [7:0]                  h_counter,
  output logic [7:0]                  v_counter
);

  logic int_active;
  logic [$clog2(video_timing_pkg::INT_LENGTH)-1:0] int_count;
  logic int_start;
  logic h_border;
  logic v_border;
  video_timing_pkg::hcount_t x_full;
  video_timing_pkg::vcount_t y_full;

  // Raster counters, vc steps when hc wraps
  always_ff @(posedge clk) begin
    if (reset) begin
      hc <= '0;
      vc <= '0;
    end else if (hc == video_timing_pkg::hcount_t'(video_timing_pkg::H_TOTAL - 1)) begin
      hc <= '0;
      if (vc == video_timing_pkg::vcount_t'(video_timing_pkg::V_TOTAL - 1)) begin
        vc <= '0;
      end else begin
        vc <= vc + 1'b1;
      end
    end else begin
      hc <= hc + 1'b1;
    end
  end

  // Frame interrupt starts at the first cycle of horizontal sync on the first vsync line
  assign int_start = vert_retrace_int &&
      hc == video_timing_pkg::hcount_t'(video_timing_pkg::H_ACTIVE + video_timing_pkg::H_FRONT) &&
      vc == video_timing_pkg::vcount_t'(video_timing_pkg::V_ACTIVE + video_timing_pkg::V_FRONT);

  always_ff @(posedge clk) begin
    if (reset) begin
      int_active <= 1'b0;
      int_count  <= '0;
    end else if (int_start) begin
      int_active <= 1'b1;
      int_count  <= '0;
    end else if (int_active) begin
      int_count <= int_count + 1'b1;
      if (int_count == $bits(int_count)'(video_timing_pkg::INT_LENGTH - 1)) begin
        int_active <= 1'b0;
      end
    end
  end

  assign n_int = ~int_active;

  // Sync pulses are active low
  assign hs = !(hc >= video_timing_pkg::hcount_t'(video_timing_pkg::H_ACTIVE +
                                                  video_timing_pkg::H_FRONT) &&
                hc <  video_timing_pkg::hcount_t'(video_timing_pkg::H_ACTIVE +
                                                  video_timing_pkg::H_FRONT +
                                                  video_timing_pkg::H_SYNC));
  assign vs = !(vc >= video_timing_pkg::vcount_t'(video_timing_pkg::V_ACTIVE +
                                                  video_timing_pkg::V_FRONT) &&
                vc <  video_timing_pkg::vcount_t'(video_timing_pkg::V_ACTIVE +
                                                  video_timing_pkg::V_FRONT +
                                                  video_timing_pkg::V_SYNC));
  assign de = hc < video_timing_pkg::hcount_t'(video_timing_pkg::H_ACTIVE) &&
              vc < video_timing_pkg::vcount_t'(video_timing_pkg::V_ACTIVE);

  // Text area is 40 cells of 6 double-width pixels after the left border
  assign h_border = hc < video_timing_pkg::hcount_t'(video_timing_pkg::H_BORDER +
                                                     video_timing_pkg::H_BORDER_ADJ) ||
                    hc >= video_timing_pkg::hcount_t'(video_timing_pkg::H_BORDER +
                                                      video_timing_pkg::H_BORDER_ADJ +
                                                      vdp_pkg::TEXT_COLUMNS *
                                                      vdp_pkg::CHAR_WIDTH * 2);
  assign v_border = vc < video_timing_pkg::vcount_t'(video_timing_pkg::V_BORDER) ||
                    vc >= video_timing_pkg::vcount_t'(video_timing_pkg::V_ACTIVE -
                                                      video_timing_pkg::V_BORDER);
  assign border = h_border || v_border;

  // Pixel coordinates for the CPU, each pixel is two clocks and two lines
  assign x_full = hc - video_timing_pkg::hcount_t'(video_timing_pkg::H_BORDER +
                                                   video_timing_pkg::H_BORDER_ADJ);
  assign y_full = vc - video_timing_pkg::vcount_t'(video_timing_pkg::V_BORDER);
  assign h_counter = x_full[8:1];
  assign v_counter = y_full[8:1];

endmodule

// File: hw/vdp_ram.sv
`timescale 1ns/100ps

module vdp_ram #(
  parameter type data_t = logic [7:0],
  parameter int DEPTH = 16,
  parameter data_t INIT [DEPTH] = '{default: '0}
) (
  input  logic                clk,
  input  logic                we,
  input  vdp_pkg::vram_addr_t waddr,
  input  data_t               wdata,
  input  vdp_pkg::vram_addr_t raddr_a,
  output data_t               rdata_a,
  input  vdp_pkg::vram_addr_t raddr_b,
  output data_t               rdata_b
);

  // Contents start from INIT, all zero unless a table is given
  data_t mem [DEPTH] = INIT;

  // One write port, two registered read ports
  // Only the low address bits that cover DEPTH are decoded
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[$clog2(DEPTH)-1:0]] <= wdata;
    end
    rdata_a <= mem[raddr_a[$clog2(DEPTH)-1:0]];
    rdata_b <= mem[raddr_b[$clog2(DEPTH)-1:0]];
  end

endmodule

// File: hw/vdp_top.sv
`timescale 1ns/100ps

module vdp_top (
  input  logic                  clk,
  input  logic                  reset,
  input  vdp_pkg::vram_addr_t   cpu_addr,
  input  vdp_pkg::vram_data_t   cpu_din,
  input  logic                  cpu_wr,
  input  logic                  cpu_rd,
  input  logic                  cram_selected,
  output vdp_pkg::vram_data_t   cpu_dout,
  input  logic                  video_on,
  input  logic                  vert_retrace_int,
  input  vdp_pkg::vram_addr_t   name_table_addr,
  input  vdp_pkg::vram_addr_t   font_addr,
  input  vdp_pkg::color_index_t text_color,
  input  vdp_pkg::color_index_t back_color,
  output logic [7:0]            vga_r,
  output logic [7:0]            vga_g,
  output logic [7:0]            vga_b,
  output logic                  vga_hs,
  output logic                  vga_vs,
  output logic                  vga_de,
  output logic                  n_int,
  output logic [7:0]            h_counter,
  output logic [7:0]            v_counter
);

  video_timing_pkg::hcount_t hc;
  video_timing_pkg::vcount_t vc;
  logic hs;
  logic vs;
  logic de;
  logic border;
  vdp_pkg::vram_addr_t vram_rd_addr;
  vdp_pkg::vram_data_t vram_rd_data;
  vdp_pkg::vram_data_t vram_cpu_data;
  vdp_pkg::vram_data_t dout_hold;
  vdp_pkg::color_index_t pixel_index;
  logic rd_valid;

  // 16 KB video RAM, CPU on port a and the text fetch on port b
  vdp_ram #(
    .data_t (vdp_pkg::vram_data_t),
    .DEPTH  (2 ** $bits(vdp_pkg::vram_addr_t))
  ) u_vram (
    .clk     (clk),
    .we      (cpu_wr && !cram_selected),
    .waddr   (cpu_addr),
    .wdata   (cpu_din),
    .raddr_a (cpu_addr),
    .rdata_a (vram_cpu_data),
    .raddr_b (vram_rd_addr),
    .rdata_b (vram_rd_data)
  );

  // Read data shows the cycle after cpu_rd and then holds
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= cpu_rd;
    end
  end

  always_ff @(posedge clk) begin
    dout_hold <= cpu_dout;
  end

  assign cpu_dout = rd_valid ? vram_cpu_data : dout_hold;

  raster_timing u_timing (
    .clk              (clk),
    .reset            (reset),
    .vert_retrace_int (vert_retrace_int),
    .hc               (hc),
    .vc               (vc),
    .hs               (hs),
    .vs               (vs),
    .de               (de),
    .border           (border),
    .n_int            (n_int),
    .h_counter        (h_counter),
    .v_counter        (v_counter)
  );

  text_fetch u_fetch (
    .clk             (clk),
    .reset           (reset),
    .hc              (hc),
    .vc              (vc),
    .video_on        (video_on),
    .name_table_addr (name_table_addr),
    .font_addr       (font_addr),
    .text_color      (text_color),
    .back_color      (back_color),
    .vram_rd_addr    (vram_rd_addr),
    .vram_rd_data    (vram_rd_data),
    .pixel_index     (pixel_index)
  );

  // Syncs idle and display disabled while in reset
  color_output u_color (
    .clk           (clk),
    .cpu_addr      (cpu_addr),
    .cpu_din       (cpu_din),
    .cpu_wr        (cpu_wr),
    .cram_selected (cram_selected),
    .pixel_index   (pixel_index),
    .back_color    (back_color),
    .border        (border),
    .hs            (hs | reset),
    .vs            (vs | reset),
    .de            (de & ~reset),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .vga_hs        (vga_hs),
    .vga_vs        (vga_vs),
    .vga_de        (vga_de)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the VDP testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module vdp_tb \
  -Mdir obj_dir -o vdp_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/vdp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// File: tests/vdp_asserts.sv
`timescale 1ns/100ps

module vdp_asserts (
  input logic clk,
  input logic reset,
  input logic hs,
  input logic vs,
  input logic de,
  input logic n_int
);

  int hs_low_len;
  int int_low_len;

  // Length of the current low phase of each pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      hs_low_len  <= 0;
      int_low_len <= 0;
    end else begin
      hs_low_len  <= hs ? 0 : hs_low_len + 1;
      int_low_len <= n_int ? 0 : int_low_len + 1;
    end
  end

  hsync_width: assert property (@(posedge clk) disable iff (reset)
      $rose(hs) |-> hs_low_len == video_timing_pkg::H_SYNC)
    else $error("hs low for %0d cycles", hs_low_len);

  int_width: assert property (@(posedge clk) disable iff (reset)
      $rose(n_int) |-> int_low_len == video_timing_pkg::INT_LENGTH)
    else $error("n_int low for %0d cycles", int_low_len);

  // Display enable stays off through both sync pulses
  no_de_in_sync: assert property (@(posedge clk) disable iff (reset)
      !(de && (!hs || !vs)))
    else $error("de high during sync");

endmodule

bind raster_timing vdp_asserts u_asserts (
  .clk   (clk),
  .reset (reset),
  .hs    (hs),
  .vs    (vs),
  .de    (de),
  .n_int (n_int)
);

// File: tests/vdp_tb.sv
`timescale 1ns/100ps

module vdp_tb;

  localparam int FRAME_CYCLES = video_timing_pkg::H_TOTAL * video_timing_pkg::V_TOTAL;
  localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 16 * video_timing_pkg::H_TOTAL;
  localparam int TEXT_LEFT = video_timing_pkg::H_BORDER + video_timing_pkg::H_BORDER_ADJ;

  logic clk = 1'b0;
  logic reset;
  vdp_pkg::vram_addr_t cpu_addr;
  vdp_pkg::vram_data_t cpu_din;
  logic cpu_wr;
  logic cpu_rd;
  logic cram_selected;
  vdp_pkg::vram_data_t cpu_dout;
  logic video_on;
  logic vert_retrace_int;
  vdp_pkg::vram_addr_t name_table_addr;
  vdp_pkg::vram_addr_t font_addr;
  vdp_pkg::color_index_t text_color;
  vdp_pkg::color_index_t back_color;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic vga_hs;
  logic vga_vs;
  logic vga_de;
  logic n_int;
  logic [7:0] h_counter;
  logic [7:0] v_counter;

  // Shadow copies of video RAM and colour RAM
  vdp_pkg::vram_data_t shadow [16384];
  vdp_pkg::rgb_t pal [vdp_pkg::PALETTE_SIZE];

  int errs [1:7];
  int cycles;
  int phase;
  logic pix_check;
  logic timing_check;
  int line;
  int col;
  logic prev_de;
  logic prev_hs;
  logic prev_vs;
  logic prev_int;
  int de_run;
  int hs_low;
  int en_lines;
  int int_low;
  int int_falls;
  int text_seen;
  int back_seen;
  int border_seen;

  vdp_top DUT (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic vdp_pkg::vram_data_t expected_byte(input vdp_pkg::vram_addr_t addr);
    return shadow[addr];
  endfunction

  function automatic logic is_border(input int ln, input int cl);
    return cl < TEXT_LEFT || cl >= TEXT_LEFT + 480 ||
           ln < video_timing_pkg::V_BORDER || ln >= 480 - video_timing_pkg::V_BORDER;
  endfunction

  function automatic vdp_pkg::color_index_t expected_index(input int ln, input int cl);
    int x;
    int y;
    int addr;
    vdp_pkg::vram_data_t code;
    vdp_pkg::vram_data_t fline;
    if (is_border(ln, cl) || !video_on) begin
      return back_color;
    end
    x = (cl - TEXT_LEFT) >> 1;
    y = (ln - video_timing_pkg::V_BORDER) >> 1;
    addr = (int'(name_table_addr) + (y / 8) * 40 + x / 6) % 16384;
    code = shadow[addr];
    addr = (int'(font_addr) + int'(code) * 8 + y % 8) % 16384;
    fline = shadow[addr];
    return fline[3'(7 - x % 6)] ? text_color : back_color;
  endfunction

  function automatic vdp_pkg::rgb_t expected_rgb(input int ln, input int cl);
    return pal[expected_index(ln, cl)];
  endfunction

  task automatic log_error(input int test, input string msg);
    errs[test]++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  task automatic compare_byte(input int test, input vdp_pkg::vram_data_t got,
                              input vdp_pkg::vram_data_t exp, input string what);
    if (got !== exp) begin
      log_error(test, $sformatf("%s got %02h expected %02h", what, got, exp));
    end
  endtask

  task automatic compare_rgb(input int test, input vdp_pkg::rgb_t got,
                             input vdp_pkg::rgb_t exp, input string what);
    if (got !== exp) begin
      log_error(test, $sformatf("%s got %06h expected %06h", what, got, exp));
    end
  endtask

  task automatic compare_counter(input int test, input logic [7:0] got,
                                 input logic [7:0] exp, input string what);
    if (got !== exp) begin
      log_error(test, $sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic compare_count(input int test, input int got, input int exp,
                               input string what);
    if (got != exp) begin
      log_error(test, $sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic write_vram(input vdp_pkg::vram_addr_t addr, input vdp_pkg::vram_data_t data);
    @(posedge clk);
    #10;
    cpu_addr = addr;
    cpu_din = data;
    cram_selected = 1'b0;
    cpu_wr = 1'b1;
    shadow[addr] = data;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    #10;
    cpu_wr = 1'b0;
    cpu_rd = 1'b0;
    cram_selected = 1'b0;
  endtask

  task automatic read_vram(input vdp_pkg::vram_addr_t addr, output vdp_pkg::vram_data_t data);
    @(posedge clk);
    #10;
    cpu_addr = addr;
    cpu_rd = 1'b1;
    @(posedge clk);
    #10;
    cpu_rd = 1'b0;
    @(negedge clk);
    data = cpu_dout;
  endtask

  task automatic write_cram(input vdp_pkg::color_index_t idx, input vdp_pkg::vram_data_t data);
    @(posedge clk);
    #10;
    cpu_addr = vdp_pkg::vram_addr_t'(idx);
    cpu_din = data;
    cram_selected = 1'b1;
    cpu_wr = 1'b1;
    pal[idx] = {data[1:0], 6'b0, data[3:2], 6'b0, data[5:4], 6'b0};
    bus_idle();
  endtask

  // Vertical sync start marks the gap between frames
  task automatic wait_vblank();
    @(negedge vga_vs);
    @(posedge clk);
    #10;
  endtask

  task automatic report_test(input int test, input string name);
    $display("Test %0d %s: %s, %0d errors", test, name,
             errs[test] == 0 ? "ok" : "mismatch", errs[test]);
  endtask

  // Output monitor, samples between clock edges
  always @(negedge clk) begin
    if (reset) begin
      line = 0;
      col = 0;
      de_run = 0;
      hs_low = 0;
      en_lines = 0;
      int_low = 0;
    end else begin
      if (vga_de) begin
        if (pix_check) begin
          if (is_border(line, col)) begin
            border_seen++;
          end else if ({vga_r, vga_g, vga_b} == pal[text_color]) begin
            text_seen++;
          end else if ({vga_r, vga_g, vga_b} == pal[back_color]) begin
            back_seen++;
          end
          compare_rgb(phase == 2 ? (is_border(line, col) ? 5 : 6) : 4,
                      {vga_r, vga_g, vga_b}, expected_rgb(line, col),
                      $sformatf("pixel line %0d col %0d", line, col));
          // The CPU counters follow the raster one cycle ahead of the video outputs
          if (!is_border(line, col + 1)) begin
            compare_counter(7, h_counter, 8'((col + 1 - TEXT_LEFT) >> 1),
                            $sformatf("h_counter line %0d col %0d", line, col));
            compare_counter(7, v_counter, 8'((line - video_timing_pkg::V_BORDER) >> 1),
                            $sformatf("v_counter line %0d col %0d", line, col));
          end
        end
        col++;
        de_run++;
      end
      if (prev_de && !vga_de) begin
        if (timing_check) begin
          compare_count(2, de_run, 640, "vga_de run");
        end
        line++;
        col = 0;
        de_run = 0;
        en_lines++;
      end
      if (!vga_hs) begin
        hs_low++;
      end else if (!prev_hs) begin
        if (timing_check) begin
          compare_count(2, hs_low, 96, "vga_hs low length");
        end
        hs_low = 0;
      end
      if (prev_vs && !vga_vs) begin
        if (timing_check) begin
          compare_count(2, en_lines, 480, "enabled lines");
        end
        en_lines = 0;
      end
      if (!vga_vs) begin
        line = 0;
      end
      if (!n_int) begin
        if (prev_int) begin
          int_falls++;
        end
        int_low++;
      end else if (!prev_int) begin
        compare_count(3, int_low, 64, "n_int low length");
        int_low = 0;
      end
    end
    prev_de = vga_de;
    prev_hs = vga_hs;
    prev_vs = vga_vs;
    prev_int = n_int;
  end

  initial begin
    vdp_pkg::vram_addr_t addrs [64];
    vdp_pkg::vram_data_t got;
    int total;
    int failed;
    reset = 1'b1;
    cpu_addr = '0;
    cpu_din = '0;
    cpu_wr = 1'b0;
    cpu_rd = 1'b0;
    cram_selected = 1'b0;
    video_on = 1'b1;
    vert_retrace_int = 1'b1;
    name_table_addr = 14'h0000;
    font_addr = 14'h0800;
    text_color = 4'd15;
    back_color = 4'd4;
    pix_check = 1'b0;
    timing_check = 1'b0;
    phase = 0;
    cycles = 0;
    text_seen = 0;
    back_seen = 0;
    border_seen = 0;
    prev_de = 1'b0;
    prev_hs = 1'b1;
    prev_vs = 1'b1;
    prev_int = 1'b1;
    int_falls = 0;
    for (int i = 1; i <= 7; i++) begin
      errs[i] = 0;
    end
    for (int i = 0; i < 16384; i++) begin
      shadow[i] = '0;
    end
    for (int i = 0; i < vdp_pkg::PALETTE_SIZE; i++) begin
      pal[i] = vdp_pkg::DEFAULT_PALETTE[i];
    end
    void'($urandom(32'hb165));
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;

    // Random bytes in the upper 4 KB, away from the name table and font
    for (int i = 0; i < 64; i++) begin
      addrs[i] = 14'h3000 | vdp_pkg::vram_addr_t'($urandom % 4096);
      write_vram(addrs[i], vdp_pkg::vram_data_t'($urandom));
    end
    bus_idle();
    for (int i = 0; i < 64; i++) begin
      read_vram(addrs[i], got);
      compare_byte(1, got, expected_byte(addrs[i]), $sformatf("cpu_dout at %04h", addrs[i]));
    end
    report_test(1, "memory readback");

    // 30 rows of 40 codes, then 256 characters of 8 font lines
    for (int i = 0; i < 1200; i++) begin
      write_vram(name_table_addr + vdp_pkg::vram_addr_t'(i), vdp_pkg::vram_data_t'($urandom));
    end
    for (int i = 0; i < 2048; i++) begin
      write_vram(font_addr + vdp_pkg::vram_addr_t'(i), vdp_pkg::vram_data_t'($urandom));
    end
    bus_idle();

    wait_vblank();
    phase = 1;
    pix_check = 1'b1;
    timing_check = 1'b1;
    int_falls = 0;
    wait_vblank();
    compare_count(3, int_falls, 1, "interrupts with retrace enabled");
    if (text_seen == 0 || back_seen == 0) begin
      $display("Text area did not show both text and back colours");
      errs[4]++;
    end
    report_test(4, "text rendering");

    // Next frame with a new back colour, display off and no interrupt
    write_cram(back_color, vdp_pkg::vram_data_t'($urandom % 64));
    video_on = 1'b0;
    vert_retrace_int = 1'b0;
    phase = 2;
    int_falls = 0;
    border_seen = 0;
    wait_vblank();
    @(posedge vga_vs);
    compare_count(3, int_falls, 0, "interrupts with retrace disabled");
    if (border_seen == 0) begin
      $display("No border pixels were checked after the colour RAM write");
      errs[5]++;
    end
    report_test(2, "sync timing");
    report_test(3, "frame interrupt");
    report_test(5, "colour RAM write");
    report_test(6, "display off");
    report_test(7, "pixel counters");

    total = 0;
    failed = 0;
    for (int i = 1; i <= 7; i++) begin
      total += errs[i];
      if (errs[i] != 0) begin
        failed++;
      end
    end
    $display("Tests run 7, failed %0d, errors %0d", failed, total);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: text_mode/color_output.sv
`timescale 1ns/100ps

module color_output (
  input  logic                  clk,
  input  vdp_pkg::vram_addr_t   cpu_addr,
  input  vdp_pkg::vram_data_t   cpu_din,
  input  logic                  cpu_wr,
  input  logic                  cram_selected,
  input  vdp_pkg::color_index_t pixel_index,
  input  vdp_pkg::color_index_t back_color,
  input  logic                  border,
  input  logic                  hs,
  input  logic                  vs,
  input  logic                  de,
  output logic [7:0]            vga_r,
  output logic [7:0]            vga_g,
  output logic [7:0]            vga_b,
  output logic                  vga_hs,
  output logic                  vga_vs,
  output logic                  vga_de
);

  logic cram_we;
  vdp_pkg::rgb_t cram_wdata;
  vdp_pkg::rgb_t border_rgb;
  vdp_pkg::rgb_t pixel_rgb;
  vdp_pkg::rgb_t color;
  logic border_q;

  // CPU writes 2 bits per channel, placed at the top of each byte
  assign cram_we = cpu_wr && cram_selected &&
                   cpu_addr < vdp_pkg::vram_addr_t'(vdp_pkg::PALETTE_SIZE);
  assign cram_wdata = '{r: {cpu_din[1:0], 6'b0},
                        g: {cpu_din[3:2], 6'b0},
                        b: {cpu_din[5:4], 6'b0}};

  // Port a looks up the border colour, port b the pixel colour
  vdp_ram #(
    .data_t (vdp_pkg::rgb_t),
    .DEPTH  (vdp_pkg::PALETTE_SIZE),
    .INIT   (vdp_pkg::DEFAULT_PALETTE)
  ) u_cram (
    .clk     (clk),
    .we      (cram_we),
    .waddr   (cpu_addr),
    .wdata   (cram_wdata),
    .raddr_a (vdp_pkg::vram_addr_t'(back_color)),
    .rdata_a (border_rgb),
    .raddr_b (vdp_pkg::vram_addr_t'(pixel_index)),
    .rdata_b (pixel_rgb)
  );

  // Match the one cycle of the palette read
  always_ff @(posedge clk) begin
    border_q <= border;
    vga_hs   <= hs;
    vga_vs   <= vs;
    vga_de   <= de;
  end

  assign color = border_q ? border_rgb : pixel_rgb;

  // Black outside the active area
  assign vga_r = vga_de ? color.r : 8'h00;
  assign vga_g = vga_de ? color.g : 8'h00;
  assign vga_b = vga_de ? color.b : 8'h00;

endmodule

// File: text_mode/text_fetch.sv
`timescale 1ns/100ps

module text_fetch (
  input  logic                      clk,
  input  logic                      reset,
  input  video_timing_pkg::hcount_t hc,
  input  video_timing_pkg::vcount_t vc,
  input  logic                      video_on,
  input  vdp_pkg::vram_addr_t       name_table_addr,
  input  vdp_pkg::vram_addr_t       font_addr,
  input  vdp_pkg::color_index_t     text_color,
  input  vdp_pkg::color_index_t     back_color,
  output vdp_pkg::vram_addr_t       vram_rd_addr,
  input  vdp_pkg::vram_data_t       vram_rd_data,
  output vdp_pkg::color_index_t     pixel_index
);

  logic [2:0] x_pix;
  logic [5:0] x_char;
  logic [5:0] next_char;
  logic line_preset;
  video_timing_pkg::vcount_t y_full;
  logic [7:0] y;
  logic [4:0] char_row;
  logic [2:0] char_line;
  vdp_pkg::vram_data_t font_line;
  logic [2:0] bit_sel;

  // Text row and line within the character from the display line
  assign y_full    = vc - video_timing_pkg::vcount_t'(video_timing_pkg::V_BORDER);
  assign y         = y_full[8:1];
  assign char_row  = 5'(y / vdp_pkg::CHAR_HEIGHT);
  assign char_line = 3'(y % vdp_pkg::CHAR_HEIGHT);

  assign next_char = x_char + 6'd1;

  // Preset one cell before the text area so the first font byte
  // is ready when column 0 starts
  assign line_preset =
      hc == video_timing_pkg::hcount_t'(video_timing_pkg::H_BORDER +
                                        video_timing_pkg::H_BORDER_ADJ -
                                        2 * vdp_pkg::CHAR_WIDTH - 1);

  // Cell counters step on odd cycles, one pixel every two clocks
  always_ff @(posedge clk) begin
    if (reset) begin
      x_pix  <= '0;
      x_char <= '0;
    end else if (line_preset) begin
      x_pix  <= '0;
      x_char <= '1;
    end else if (hc[0]) begin
      if (x_pix == 3'(vdp_pkg::CHAR_WIDTH - 1)) begin
        x_pix  <= '0;
        x_char <= next_char;
      end else begin
        x_pix <= x_pix + 3'd1;
      end
    end
  end

  // Fetch for the next cell during the last three pixels of this one
  // RAM data returns one cycle after the address
  always_ff @(posedge clk) begin
    if (hc[0]) begin
      case (x_pix)
        3'd3: begin
          // Name table entry of the next cell
          vram_rd_addr <= name_table_addr +
                          vdp_pkg::vram_addr_t'(char_row * vdp_pkg::TEXT_COLUMNS) +
                          vdp_pkg::vram_addr_t'(next_char);
        end
        3'd4: begin
          // Font line of that character
          vram_rd_addr <= font_addr +
                          vdp_pkg::vram_addr_t'(vram_rd_data * vdp_pkg::CHAR_HEIGHT) +
                          vdp_pkg::vram_addr_t'(char_line);
        end
        3'd5: begin
          font_line <= vram_rd_data;
        end
        default: begin
        end
      endcase
    end
  end

  // Leftmost pixel of the cell is bit 7
  assign bit_sel = 3'd7 - x_pix;

  assign pixel_index = (video_on && font_line[bit_sel]) ? text_color : back_color;

endmodule
